// ==== hdl/frontend_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// ========================================
// Front end sizing
// ========================================

// Address and fetch data width
`define FE_XLEN 32

// Fetch buffer depth, counted in halfwords
`define FE_FBUF_HW 4

// First fetch address after reset
`define FE_RESET_VECTOR 32'h0000_0000

`endif

// ==== hdl/frontend_pkg.sv ====
`include "frontend_params.svh"

package frontend_pkg;

	// ========================================
	// RV32 base opcodes, instr[6:0]
	// ========================================
	localparam logic [6:0] LOAD     = 7'b0000011;
	localparam logic [6:0] MISC_MEM = 7'b0001111;
	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] AUIPC    = 7'b0010111;
	localparam logic [6:0] STORE    = 7'b0100011;
	localparam logic [6:0] OP       = 7'b0110011;
	localparam logic [6:0] LUI      = 7'b0110111;
	localparam logic [6:0] BRANCH   = 7'b1100011;
	localparam logic [6:0] JALR     = 7'b1100111;
	localparam logic [6:0] JAL      = 7'b1101111;
	localparam logic [6:0] SYSTEM   = 7'b1110011;

	// Instruction class, C marks a 16-bit instruction
	typedef enum logic [2:0] {R, I, S, B, U, J, C} iclass_e;

	// Register and opcode fields of a 32-bit instruction
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_fields_t;

	// Same word seen raw or split into fields
	typedef union packed {
		logic [31:0]   raw;
		instr_fields_t f;
	} instr_word_u;

	typedef struct packed {
		logic                strobe;
		logic [`FE_XLEN-1:0] addr;
	} fetch_req_t;

	// Sequencer to buffer, one memory response per cycle at most
	typedef struct packed {
		logic        valid;
		logic        flush;
		logic        skip_low;
		logic [31:0] data;
	} fill_t;

	typedef struct packed {
		logic [31:0] data;
		logic [2:0]  level;
	} buf_head_t;

	typedef struct packed {
		logic [`FE_XLEN-1:0] pc;
		logic [31:0]         raw;
		logic [31:0]         imm;
		logic [4:0]          rd;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		iclass_e             iclass;
		logic                is_compressed;
		logic                invalid;
	} decoded_instr_t;

endpackage

// ==== hdl/fetch_sequencer.sv ====
`timescale 1ns/10ps
`include "frontend_params.svh"

module fetch_sequencer
	import frontend_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                jump_i,
	input  logic [`FE_XLEN-1:0] jump_target_i,
	input  logic [2:0]          level_i,
	input  logic                fetch_valid_i,
	input  logic [`FE_XLEN-1:0] fetch_rdata_i,
	output fetch_req_t          fetch_o,
	output fill_t               fill_o
);

	localparam logic [`FE_XLEN-1:0] WORD_STEP = 4;
	// Room for one more word without passing the buffer depth
	localparam logic [2:0] REFILL_LEVEL = 3'(`FE_FBUF_HW - 2);

	fetch_req_t          req_q;
	logic [`FE_XLEN-1:0] next_addr_q;
	logic                in_flight_q;
	logic                stale_q;
	logic                unaligned_q;

	logic                issue;
	logic                resp_ok;
	logic [`FE_XLEN-1:0] jump_base;

	assign jump_base = {jump_target_i[`FE_XLEN-1:2], 2'b00};
	assign issue     = !in_flight_q && (level_i <= REFILL_LEVEL);

	// Responses to requests made before a redirect never reach the buffer
	assign resp_ok = fetch_valid_i && !stale_q && !jump_i;

	always_comb begin
		fill_o.valid    = resp_ok;
		fill_o.flush    = jump_i;
		fill_o.skip_low = unaligned_q;
		fill_o.data     = fetch_rdata_i;
	end

	assign fetch_o = req_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_q       <= '0;
			next_addr_q <= `FE_RESET_VECTOR;
			in_flight_q <= 1'b0;
			stale_q     <= 1'b0;
			unaligned_q <= 1'b0;
		end else begin
			// A request on the bus during a jump answers into the old stream
			stale_q <= jump_i && req_q.strobe;
			if (jump_i) begin
				req_q.strobe <= 1'b1;
				req_q.addr   <= jump_base;
				next_addr_q  <= jump_base + WORD_STEP;
				in_flight_q  <= 1'b1;
				unaligned_q  <= jump_target_i[1];
			end else begin
				req_q.strobe <= issue;
				if (issue) begin
					req_q.addr  <= next_addr_q;
					next_addr_q <= next_addr_q + WORD_STEP;
					in_flight_q <= 1'b1;
				end else if (fetch_valid_i && !stale_q) begin
					in_flight_q <= 1'b0;
				end
				// only the first word after the jump loses its low half
				if (resp_ok) begin
					unaligned_q <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== hdl/halfword_buffer.sv ====
`timescale 1ns/10ps
`include "frontend_params.svh"

module halfword_buffer
	import frontend_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  fill_t     fill_i,
	input  logic [1:0] consume_i,
	output buf_head_t head_o,
	output logic [2:0] level_o
);

	localparam int BUF_W = `FE_FBUF_HW * 16;

	logic [BUF_W-1:0]    buf_q;
	logic [2:0]          level_q;

	logic [BUF_W-1:0]    kept;
	logic [2:0]          base_lvl;
	logic [2:0]          add_lvl;
	logic [31:0]         word;
	logic [BUF_W+31:0]   merged;

	// ========================================
	// Drain from the bottom
	// ========================================

	// Flush wins over consume, the append below still lands
	always_comb begin
		if (fill_i.flush) begin
			kept     = '0;
			base_lvl = 3'd0;
		end else begin
			kept     = buf_q >> {consume_i, 4'b0000};
			base_lvl = level_q - {1'b0, consume_i};
		end
	end

	// ========================================
	// Append above what remains
	// ========================================

	always_comb begin
		if (!fill_i.valid) begin
			word    = 32'h0;
			add_lvl = 3'd0;
		end else if (fill_i.skip_low) begin
			// Jump target sits in the upper halfword
			word    = {16'h0, fill_i.data[31:16]};
			add_lvl = 3'd1;
		end else begin
			word    = fill_i.data;
			add_lvl = 3'd2;
		end
		merged = {32'h0, kept} | ({{BUF_W{1'b0}}, word} << {base_lvl, 4'b0000});
	end

	// Store stays zero above the level so the OR merge is clean
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_q   <= '0;
			level_q <= 3'd0;
		end else begin
			buf_q   <= merged[BUF_W-1:0];
			level_q <= base_lvl + add_lvl;
		end
	end

	assign head_o.data  = buf_q[31:0];
	assign head_o.level = level_q;
	assign level_o      = level_q;

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/10ps
`include "frontend_params.svh"

module instr_decoder
	import frontend_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  buf_head_t           head_i,
	input  logic                jump_i,
	input  logic [`FE_XLEN-1:0] jump_target_i,
	output logic [1:0]          consume_o,
	output logic                instr_valid_o,
	output decoded_instr_t      instr_o
);

	instr_word_u         iw;
	logic                is_full;
	logic                take;
	logic [`FE_XLEN-1:0] pc_q;
	logic [`FE_XLEN-1:0] pc_step;

	logic [31:0]         imm_i;
	logic [31:0]         imm_s;
	logic [31:0]         imm_b;
	logic [31:0]         imm_u;
	logic [31:0]         imm_j;

	iclass_e             cls;
	logic [31:0]         imm;
	logic                invalid;

	logic                valid_q;
	decoded_instr_t      instr_q;

	assign iw.raw = head_i.data;

	// ========================================
	// Length and consume
	// ========================================
	assign is_full   = (iw.raw[1:0] == 2'b11);
	// Nothing is taken in the jump cycle, the old stream is dead
	assign take      = !jump_i && (head_i.level >= (is_full ? 3'd2 : 3'd1));
	assign consume_o = take ? (is_full ? 2'd2 : 2'd1) : 2'd0;
	assign pc_step   = is_full ? `FE_XLEN'(4) : `FE_XLEN'(2);

	// Immediate scatter per format
	assign imm_i = {{20{iw.raw[31]}}, iw.raw[31:20]};
	assign imm_s = {{20{iw.raw[31]}}, iw.raw[31:25], iw.raw[11:7]};
	assign imm_b = {{19{iw.raw[31]}}, iw.raw[31], iw.raw[7], iw.raw[30:25], iw.raw[11:8], 1'b0};
	assign imm_u = {iw.raw[31:12], 12'h000};
	assign imm_j = {{11{iw.raw[31]}}, iw.raw[31], iw.raw[19:12], iw.raw[20], iw.raw[30:21], 1'b0};

	always_comb begin
		cls     = R;
		imm     = 32'h0;
		invalid = 1'b0;
		case (iw.f.opcode)
			LOAD, OP_IMM, JALR, MISC_MEM, SYSTEM: begin
				cls = I;
				imm = imm_i;
			end
			STORE: begin
				cls = S;
				imm = imm_s;
			end
			BRANCH: begin
				cls = B;
				imm = imm_b;
			end
			LUI, AUIPC: begin
				cls = U;
				imm = imm_u;
			end
			JAL: begin
				cls = J;
				imm = imm_j;
			end
			OP: cls = R;
			default: invalid = 1'b1;
		endcase
		// 16-bit instructions are passed out raw, no expansion
		if (!is_full) begin
			cls     = C;
			imm     = 32'h0;
			invalid = 1'b0;
		end
	end

	// ========================================
	// Output register and running pc
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			pc_q    <= `FE_RESET_VECTOR;
		end else begin
			valid_q <= take;
			if (jump_i) begin
				pc_q <= jump_target_i;
			end else if (take) begin
				pc_q <= pc_q + pc_step;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			instr_q.pc            <= pc_q;
			instr_q.raw           <= is_full ? iw.raw : {16'h0, iw.raw[15:0]};
			instr_q.imm           <= imm;
			instr_q.rd            <= is_full ? iw.f.rd : 5'd0;
			instr_q.rs1           <= is_full ? iw.f.rs1 : 5'd0;
			instr_q.rs2           <= is_full ? iw.f.rs2 : 5'd0;
			instr_q.iclass        <= cls;
			instr_q.is_compressed <= !is_full;
			instr_q.invalid       <= invalid;
		end
	end

	assign instr_valid_o = valid_q;
	assign instr_o       = instr_q;

endmodule

// ==== hdl/instr_frontend.sv ====
`timescale 1ns/10ps
`include "frontend_params.svh"

module instr_frontend
	import frontend_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                jump_i,
	input  logic [`FE_XLEN-1:0] jump_target_i,
	output fetch_req_t          fetch_o,
	input  logic                fetch_valid_i,
	input  logic [`FE_XLEN-1:0] fetch_rdata_i,
	output logic                instr_valid_o,
	output decoded_instr_t      instr_o
);

	fill_t      fill;
	buf_head_t  head;
	logic [2:0] level;
	logic [1:0] consume;

	// Word fetch and redirect
	fetch_sequencer u_seq (
		.clk           (clk),
		.rst_n         (rst_n),
		.jump_i        (jump_i),
		.jump_target_i (jump_target_i),
		.level_i       (level),
		.fetch_valid_i (fetch_valid_i),
		.fetch_rdata_i (fetch_rdata_i),
		.fetch_o       (fetch_o),
		.fill_o        (fill)
	);

	halfword_buffer u_buf (
		.clk       (clk),
		.rst_n     (rst_n),
		.fill_i    (fill),
		.consume_i (consume),
		.head_o    (head),
		.level_o   (level)
	);

	instr_decoder u_dec (
		.clk           (clk),
		.rst_n         (rst_n),
		.head_i        (head),
		.jump_i        (jump_i),
		.jump_target_i (jump_target_i),
		.consume_o     (consume),
		.instr_valid_o (instr_valid_o),
		.instr_o       (instr_o)
	);

endmodule

// ==== testbench/frontend_asserts.sv ====
`timescale 1ns/10ps
`include "frontend_params.svh"

module frontend_asserts (
	input logic       clk,
	input logic       rst_n,
	input logic [2:0] level_i,
	input logic [1:0] consume_i,
	input logic       instr_valid_i
);

	// Count of failed assertions
	int n_fail = 0;

	// Buffer never holds more than its depth
	level_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		level_i <= 3'(`FE_FBUF_HW))
		else begin
			$error("buffer level %0d above depth", level_i);
			n_fail++;
		end

	// Decoder only takes halfwords that are present
	consume_covered: assert property (@(posedge clk) disable iff (!rst_n)
		consume_i <= level_i)
		else begin
			$error("consume %0d above level %0d", consume_i, level_i);
			n_fail++;
		end

	// No output strobe while reset is held
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !instr_valid_i)
		else begin
			$error("instr_valid_o high during reset");
			n_fail++;
		end

endmodule

// ==== testbench/tb_instr_frontend.sv ====
`timescale 1ns/10ps
`include "frontend_params.svh"

module tb_instr_frontend
	import frontend_pkg::*;
();

	localparam int MEM_WORDS  = 64;
	localparam int N_PROG     = 34;
	localparam int N_EXP      = 19;
	localparam int N_JUMP     = 2;
	localparam int TIMEOUT_NS = (N_EXP * 20 + 4) * 10;

	typedef struct packed {
		logic [31:0] pc;
		logic        is_c;
		iclass_e     iclass;
		logic [31:0] imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic        invalid;
	} expect_t;

	logic           clk;
	logic           rst_n;
	logic           jump_i;
	logic [31:0]    jump_target_i;
	fetch_req_t     fetch_o;
	logic           fetch_valid_i;
	logic [31:0]    fetch_rdata_i;
	logic           instr_valid_o;
	decoded_instr_t instr_o;

	logic [31:0] mem [MEM_WORDS];
	// Each entry is {byte address, halfword}
	logic [31:0] prog [N_PROG];
	expect_t     exp_tab [N_EXP];
	// Each entry is {cycle after reset release, target}
	logic [63:0] jumps [N_JUMP];
	fetch_req_t  req_q;
	int          cyc;
	int          n_seen;
	int          n_err;

	instr_frontend dut (.*);

	// Level, consume and output strobe all live in the top level
	bind instr_frontend frontend_asserts u_asserts (
		.clk           (clk),
		.rst_n         (rst_n),
		.level_i       (level),
		.consume_i     (consume),
		.instr_valid_i (instr_valid_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic report_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] want);
		$display("FAILED at %0t: %s got %h expected %h", $time, sig, got, want);
		n_err++;
	endtask

	// Halfword of the program image at a byte address
	function automatic logic [15:0] halfword_at(input logic [31:0] addr);
		logic [31:0] w;
		w = mem[addr[7:2]];
		return addr[1] ? w[31:16] : w[15:0];
	endfunction

	task automatic compare_request(input logic [31:0] want);
		if (fetch_o.strobe !== 1'b1)
			report_mismatch("fetch_o.strobe", 32'(fetch_o.strobe), 32'd1);
		if (fetch_o.addr !== want)
			report_mismatch("fetch_o.addr", fetch_o.addr, want);
	endtask

	task automatic check_instr();
		expect_t     e;
		int          err0;
		logic [31:0] want_raw;
		e    = exp_tab[n_seen];
		err0 = n_err;
		// 16-bit entries come out with a zero upper half
		if (e.is_c)
			want_raw = {16'h0, halfword_at(e.pc)};
		else
			want_raw = {halfword_at(e.pc + 32'd2), halfword_at(e.pc)};
		if (instr_o.pc !== e.pc)
			report_mismatch("instr_o.pc", instr_o.pc, e.pc);
		if (instr_o.raw !== want_raw)
			report_mismatch("instr_o.raw", instr_o.raw, want_raw);
		if (instr_o.is_compressed !== e.is_c)
			report_mismatch("instr_o.is_compressed", 32'(instr_o.is_compressed), 32'(e.is_c));
		if (instr_o.iclass !== e.iclass)
			report_mismatch("instr_o.iclass", 32'(instr_o.iclass), 32'(e.iclass));
		if (instr_o.imm !== e.imm)
			report_mismatch("instr_o.imm", instr_o.imm, e.imm);
		if (instr_o.rd !== e.rd)
			report_mismatch("instr_o.rd", 32'(instr_o.rd), 32'(e.rd));
		if (instr_o.rs1 !== e.rs1)
			report_mismatch("instr_o.rs1", 32'(instr_o.rs1), 32'(e.rs1));
		if (instr_o.rs2 !== e.rs2)
			report_mismatch("instr_o.rs2", 32'(instr_o.rs2), 32'(e.rs2));
		if (instr_o.invalid !== e.invalid)
			report_mismatch("instr_o.invalid", 32'(instr_o.invalid), 32'(e.invalid));
		n_seen++;
		$display("instr %0d pc %h: %s", n_seen, e.pc, (n_err == err0) ? "ok" : "mismatch");
	endtask

	// ========================================
	// Program, expectations, jumps
	// ========================================
	initial begin
		prog = '{32'h0000_50b7, 32'h0002_1234, 32'h0004_8113, 32'h0006_ffb0,
			32'h0008_aa23, 32'h000a_fe20, 32'h000c_8ce3, 32'h000e_fe20,
			32'h0010_00ef, 32'h0012_0010, 32'h0014_81b3, 32'h0016_0020,
			32'h0018_f297, 32'h001a_ffff, 32'h001c_2303, 32'h001e_7ff1,
			32'h0040_8067, 32'h0042_ffc0, 32'h0044_11f3, 32'h0046_3052,
			32'h0060_0013, 32'h0062_4501, 32'h0064_0505, 32'h0066_0513,
			32'h0068_0015, 32'h006a_8082, 32'h006c_63b3, 32'h006e_0094,
			32'h0070_0001, 32'h0072_028b, 32'h0074_0003, 32'h0076_0093,
			32'h0078_02a0, 32'h007a_4081};
		// pc, compressed, class, imm, rd, rs1, rs2, invalid
		exp_tab = '{'{32'h00, 1'b0, U, 32'h1234_5000, 5'd1, 5'd8, 5'd3, 1'b0},
			'{32'h04, 1'b0, I, 32'hffff_fffb, 5'd2, 5'd1, 5'd27, 1'b0},
			'{32'h08, 1'b0, S, 32'hffff_fff4, 5'd20, 5'd1, 5'd2, 1'b0},
			'{32'h0c, 1'b0, B, 32'hffff_fff8, 5'd25, 5'd1, 5'd2, 1'b0},
			'{32'h10, 1'b0, J, 32'h0000_0800, 5'd1, 5'd0, 5'd1, 1'b0},
			'{32'h14, 1'b0, R, 32'h0000_0000, 5'd3, 5'd1, 5'd2, 1'b0},
			'{32'h18, 1'b0, U, 32'hffff_f000, 5'd5, 5'd31, 5'd31, 1'b0},
			'{32'h1c, 1'b0, I, 32'h0000_07ff, 5'd6, 5'd2, 5'd31, 1'b0},
			'{32'h40, 1'b0, I, 32'hffff_fffc, 5'd0, 5'd1, 5'd28, 1'b0},
			'{32'h44, 1'b0, I, 32'h0000_0305, 5'd3, 5'd4, 5'd5, 1'b0},
			'{32'h62, 1'b1, C, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 1'b0},
			'{32'h64, 1'b1, C, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 1'b0},
			'{32'h66, 1'b0, I, 32'h0000_0001, 5'd10, 5'd10, 5'd1, 1'b0},
			'{32'h6a, 1'b1, C, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 1'b0},
			'{32'h6c, 1'b0, R, 32'h0000_0000, 5'd7, 5'd8, 5'd9, 1'b0},
			'{32'h70, 1'b1, C, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 1'b0},
			'{32'h72, 1'b0, R, 32'h0000_0000, 5'd5, 5'd6, 5'd0, 1'b1},
			'{32'h76, 1'b0, I, 32'h0000_002a, 5'd1, 5'd0, 5'd10, 1'b0},
			'{32'h7a, 1'b1, C, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 1'b0}};
		// Aligned jump past the first run, then one into an upper halfword
		jumps = '{{32'd27, 32'h0000_0040}, {32'd34, 32'h0000_0062}};
	end

	// ========================================
	// Reset, memory model and checks
	// ========================================
	initial begin
		rst_n         = 1'b0;
		jump_i        = 1'b0;
		jump_target_i = 32'h0;
		fetch_valid_i = 1'b0;
		fetch_rdata_i = 32'h0;
		req_q         = '0;
		cyc           = 0;
		n_seen        = 0;
		n_err         = 0;
		// Unused words hold addi x0, x0, word index
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {12'(i), 20'h00013};
		#1;
		foreach (prog[k]) begin
			if (prog[k][17])
				mem[prog[k][23:18]][31:16] = prog[k][15:0];
			else
				mem[prog[k][23:18]][15:0] = prog[k][15:0];
		end
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		while (n_seen < N_EXP) begin
			@(posedge clk);
			#1;
			cyc++;
			// Answer last cycle's request, then latch the new one
			fetch_valid_i = req_q.strobe;
			fetch_rdata_i = mem[req_q.addr[7:2]];
			req_q         = fetch_o;
			if (cyc == 1)
				compare_request(`FE_RESET_VECTOR);
			jump_i        = 1'b0;
			for (int k = 0; k < N_JUMP; k++) begin
				if (jumps[k][63:32] == cyc) begin
					jump_i        = 1'b1;
					jump_target_i = jumps[k][31:0];
				end
				// The aligned target goes out the cycle after the jump
				if (jumps[k][63:32] + 32'd1 == cyc)
					compare_request({jumps[k][31:2], 2'b00});
			end
			if (instr_valid_o)
				check_instr();
		end
		$display("Checked %0d of %0d instructions, %0d errors, %0d assertion failures",
			n_seen, N_EXP, n_err, dut.u_asserts.n_fail);
		if (n_err == 0 && dut.u_asserts.n_fail == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout with %0d of %0d instructions received", n_seen, N_EXP);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== instr_frontend.f ====
+incdir+hdl
hdl/frontend_pkg.sv
hdl/fetch_sequencer.sv
hdl/halfword_buffer.sv
hdl/instr_decoder.sv
hdl/instr_frontend.sv
testbench/frontend_asserts.sv
testbench/tb_instr_frontend.sv

// ==== Makefile ====
TOP = tb_instr_frontend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f instr_frontend.f --top-module $(TOP)

obj_dir/V$(TOP): instr_frontend.f hdl/*.sv hdl/*.svh testbench/*.sv
	verilator --binary --timing --assert -f instr_frontend.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
